//--- compile.f
+incdir+src
src/wiener_pkg.sv
src/pixel_stream_if.sv
src/wiener_block_reader.sv
src/block_stats.sv
src/wiener_filter.sv
src/wiener_denoise_top.sv
testbench/tb_wiener_denoise.sv

//--- run_sim.sh
#!/bin/sh
# builds and runs with Verilator from the project root, the log decides the result
rm -rf obj_dir sim.log
verilator --binary --timing -f compile.f --top-module tb_wiener_denoise -o tb_sim \
	> sim.log 2>&1 \
	&& ./obj_dir/tb_sim >> sim.log 2>&1 \
	|| echo "SIMULATION FAILED" >> sim.log
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1 || exit 0

//--- src/block_stats.sv
// totals are valid only in the stats_valid cycle and are overwritten by the next block
`timescale 1ns/10ps
`include "wiener_consts.svh"

module block_stats (
	input  logic                 clk,
	input  logic                 rst_n,
	pixel_stream_if.stats_sink   strm,
	output logic                 stats_valid,
	output logic [`SUM_W-1:0]    block_sum,
	output logic [`SUMSQ_W-1:0]  block_sumsq
);

	localparam int SQ_W = 2 * `PIX_W;

	logic [SQ_W-1:0]     pix_sq;
	logic [`SUM_W-1:0]   sum_q;
	logic [`SUMSQ_W-1:0] sumsq_q;

	assign pix_sq = SQ_W'(strm.pix) * SQ_W'(strm.pix);

	// accumulators restart on the first pixel of each block
	always_ff @(posedge clk) begin
		if (strm.pix_valid) begin
			if (strm.block_first) begin
				sum_q   <= `SUM_W'(strm.pix);
				sumsq_q <= `SUMSQ_W'(pix_sq);
			end else begin
				sum_q   <= sum_q + `SUM_W'(strm.pix);
				sumsq_q <= sumsq_q + `SUMSQ_W'(pix_sq);
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			stats_valid <= 1'b0;
		else
			stats_valid <= strm.pix_valid && strm.block_last;  // totals include pixel 64
	end

	assign block_sum   = sum_q;
	assign block_sumsq = sumsq_q;

endmodule

//--- src/pixel_stream_if.sv
// pixel stream from the reader, one pixel per pix_valid, no back-pressure toward the reader
`timescale 1ns/10ps
`include "wiener_consts.svh"

interface pixel_stream_if;
	import wiener_pkg::*;

	logic               pix_valid;
	pixel_t             pix;
	logic               block_first;  // first pixel of an 8x8 block
	logic               block_last;   // 64th pixel of the block
	logic [`ADDR_W-1:0] block_addr;   // top-left pixel address, stable for the block
	logic               filter_idle;  // filter ready for a new block

	modport src (
		output pix_valid, pix, block_first, block_last, block_addr,
		input  filter_idle
	);

	modport stats_sink (
		input pix_valid, pix, block_first, block_last
	);

	modport filter_sink (
		input  pix_valid, pix, block_first, block_last, block_addr,
		output filter_idle
	);

endinterface

//--- src/wiener_block_reader.sv
// memory must return exactly 8 beats per rd_start with rlast on the 8th; settings latched at start
`timescale 1ns/10ps
`include "wiener_consts.svh"

module wiener_block_reader (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                noise_ready,
	input  logic [`ADDR_W-1:0]  base_addr,
	input  logic [`DIM_W-1:0]   frame_width,
	input  logic [`DIM_W-1:0]   frame_height,
	input  wiener_pkg::pixel_t  rdata,
	input  logic                rvalid,
	input  logic                rlast,
	output logic                rd_start,
	output logic [`ADDR_W-1:0]  rd_addr,
	output logic [7:0]          rd_len,
	output logic                start_of_frame,
	output logic                frame_done,
	pixel_stream_if.src         strm
);
	import wiener_pkg::*;

	localparam int BLK_W = `DIM_W - `BLOCK_SHIFT;  // block column / row index

	reader_state_t            state;
	logic [`ADDR_W-1:0]       base_q;
	logic [`DIM_W-1:0]        width_q;
	logic [`DIM_W-1:0]        height_q;
	logic [BLK_W-1:0]         blk_col;
	logic [BLK_W-1:0]         blk_row;
	logic [`BLOCK_SHIFT-1:0]  pix_row;   // row inside the block
	logic [`BLOCK_SHIFT-1:0]  beat_cnt;  // beat inside the row burst
	logic [`DIM_W-1:0]        row_idx;
	logic [`DIM_W-1:0]        col_off;
	logic [`ADDR_W-1:0]       burst_addr;
	logic                     last_col;
	logic                     last_row;
	logic                     issue_ok;

	assign rd_len = 8'(`BLOCK_SIZE);

	// frame row = block row * 8 + pixel row
	assign row_idx    = {blk_row, pix_row};
	assign col_off    = {blk_col, {`BLOCK_SHIFT{1'b0}}};
	assign burst_addr = base_q + `ADDR_W'(row_idx) * `ADDR_W'(width_q) + `ADDR_W'(col_off);

	assign last_col = (blk_col == width_q[`DIM_W-1:`BLOCK_SHIFT] - 1'b1);
	assign last_row = (blk_row == height_q[`DIM_W-1:`BLOCK_SHIFT] - 1'b1);

	// a new block only starts once the filter has emptied
	assign issue_ok = (state == RD_ISSUE) && ((pix_row != '0) || strm.filter_idle);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state             <= RD_IDLE;
			rd_start          <= 1'b0;
			start_of_frame    <= 1'b0;
			frame_done        <= 1'b0;
			strm.pix_valid    <= 1'b0;
			strm.block_first  <= 1'b0;
			strm.block_last   <= 1'b0;
			blk_col           <= '0;
			blk_row           <= '0;
			pix_row           <= '0;
			beat_cnt          <= '0;
		end else begin
			rd_start         <= 1'b0;  // all strobes are single cycle
			start_of_frame   <= 1'b0;
			frame_done       <= 1'b0;
			strm.pix_valid   <= 1'b0;
			strm.block_first <= 1'b0;
			strm.block_last  <= 1'b0;
			case (state)
				RD_IDLE: begin
					if (noise_ready) begin
						blk_col  <= '0;
						blk_row  <= '0;
						pix_row  <= '0;
						beat_cnt <= '0;
						state    <= RD_ISSUE;
					end
				end
				RD_ISSUE: begin
					if (issue_ok) begin
						rd_start <= 1'b1;
						state    <= RD_BEATS;
					end
				end
				RD_BEATS: begin
					if (rvalid) begin
						strm.pix_valid   <= 1'b1;
						strm.block_first <= (pix_row == '0) && (beat_cnt == '0);
						strm.block_last  <= (&pix_row) && (&beat_cnt);
						start_of_frame   <= (blk_col == '0) && (blk_row == '0) &&
						                    (pix_row == '0) && (beat_cnt == '0);
						beat_cnt <= beat_cnt + 1'b1;  // wraps after the 8th beat
						if (rlast) begin
							pix_row <= pix_row + 1'b1;
							state   <= RD_ISSUE;
							if (&pix_row) begin  // block complete
								if (last_col) begin
									blk_col <= '0;
									if (last_row)
										state <= RD_DRAIN;
									else
										blk_row <= blk_row + 1'b1;
								end else begin
									blk_col <= blk_col + 1'b1;
								end
							end
						end
					end
				end
				RD_DRAIN: begin
					if (strm.filter_idle) begin  // last block fully written out
						frame_done <= 1'b1;
						state      <= RD_IDLE;
					end
				end
				default: state <= RD_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == RD_IDLE && noise_ready) begin
			base_q   <= base_addr;
			width_q  <= frame_width;
			height_q <= frame_height;
		end
		if (issue_ok) begin
			rd_addr <= burst_addr;
			if (pix_row == '0)
				strm.block_addr <= burst_addr;
		end
		if (rvalid)
			strm.pix <= rdata;
	end

endmodule

//--- src/wiener_consts.svh
// fixed 8x8 blocks; frame dimensions must be multiples of 8 and at most 1280x720
`ifndef WIENER_CONSTS_SVH
`define WIENER_CONSTS_SVH

`define BLOCK_SIZE 8   // block edge in pixels
`define BLOCK_SHIFT 3  // log2 of block edge
`define PIX_W 8        // greyscale pixel
`define ADDR_W 32
`define DIM_W 16       // frame width / height

`define MAX_WIDTH 1280
`define MAX_HEIGHT 720

`define GAIN_FRAC 8    // gain is Q8, 256 means unity
`define SUM_W 14       // 64 * 255 fits
`define SUMSQ_W 22     // 64 * 255^2 fits

`endif

//--- src/wiener_denoise_top.sv
// rd_len is fixed at 8 beats; base_addr and frame size are taken when noise_ready starts a frame
`timescale 1ns/10ps
`include "wiener_consts.svh"

module wiener_denoise_top (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                noise_ready,
	input  logic [`ADDR_W-1:0]  base_addr,
	input  logic [`DIM_W-1:0]   frame_width,
	input  logic [`DIM_W-1:0]   frame_height,
	input  logic [2*`PIX_W-1:0] noise_var,
	input  wiener_pkg::pixel_t  rdata,
	input  logic                rvalid,
	input  logic                rlast,
	output logic                rd_start,
	output logic [`ADDR_W-1:0]  rd_addr,
	output logic [7:0]          rd_len,
	output logic                out_valid,
	output wiener_pkg::pixel_t  out_pixel,
	output logic [`ADDR_W-1:0]  out_addr,
	output logic                start_of_frame,
	output logic                frame_done
);

	pixel_stream_if strm ();

	logic                 stats_valid;
	logic [`SUM_W-1:0]    block_sum;
	logic [`SUMSQ_W-1:0]  block_sumsq;

	wiener_block_reader i_reader (
		.clk            (clk),
		.rst_n          (rst_n),
		.noise_ready    (noise_ready),
		.base_addr      (base_addr),
		.frame_width    (frame_width),
		.frame_height   (frame_height),
		.rdata          (rdata),
		.rvalid         (rvalid),
		.rlast          (rlast),
		.rd_start       (rd_start),
		.rd_addr        (rd_addr),
		.rd_len         (rd_len),
		.start_of_frame (start_of_frame),
		.frame_done     (frame_done),
		.strm           (strm.src)
	);

	block_stats i_stats (
		.clk         (clk),
		.rst_n       (rst_n),
		.strm        (strm.stats_sink),
		.stats_valid (stats_valid),
		.block_sum   (block_sum),
		.block_sumsq (block_sumsq)
	);

	wiener_filter i_filter (
		.clk         (clk),
		.rst_n       (rst_n),
		.strm        (strm.filter_sink),
		.noise_var   (noise_var),
		.frame_width (frame_width),
		.stats_valid (stats_valid),
		.block_sum   (block_sum),
		.block_sumsq (block_sumsq),
		.out_valid   (out_valid),
		.out_pixel   (out_pixel),
		.out_addr    (out_addr)
	);

endmodule

//--- src/wiener_filter.sv
// one block in flight; noise_var and frame_width are sampled on each block's first pixel
`timescale 1ns/10ps
`include "wiener_consts.svh"

module wiener_filter (
	input  logic                   clk,
	input  logic                   rst_n,
	pixel_stream_if.filter_sink    strm,
	input  logic [2*`PIX_W-1:0]    noise_var,
	input  logic [`DIM_W-1:0]      frame_width,
	input  logic                   stats_valid,
	input  logic [`SUM_W-1:0]      block_sum,
	input  logic [`SUMSQ_W-1:0]    block_sumsq,
	output logic                   out_valid,
	output wiener_pkg::pixel_t     out_pixel,
	output logic [`ADDR_W-1:0]     out_addr
);
	import wiener_pkg::*;

	localparam int NPIX   = `BLOCK_SIZE * `BLOCK_SIZE;
	localparam int IDX_W  = 2 * `BLOCK_SHIFT;     // also log2 of NPIX
	localparam int VAR_W  = 2 * `PIX_W;
	localparam int GAIN_W = `GAIN_FRAC + 1;       // 0..256
	localparam int RES_W  = `PIX_W + 3;
	localparam int MAXPIX = (1 << `PIX_W) - 1;

	filter_state_t               state;
	pixel_t                      pix_buf [NPIX];
	logic [IDX_W-1:0]            wr_idx;
	logic [IDX_W-1:0]            wr_sel;
	logic [IDX_W-1:0]            rd_idx;
	logic [3:0]                  div_cnt;
	logic [`ADDR_W-1:0]          blk_addr_q;
	logic [`DIM_W-1:0]           fw_q;
	logic [VAR_W-1:0]            nv_q;
	pixel_t                      mean_q;
	logic [VAR_W-1:0]            var_q;
	logic [VAR_W:0]              rem;       // division remainder, < 2*var
	logic [VAR_W:0]              rem_sub;
	logic [GAIN_W-1:0]           gain_q;
	pixel_t                      mean_w;
	logic [VAR_W-1:0]            mean_sq;
	logic [VAR_W-1:0]            msq;
	logic [VAR_W-1:0]            var_w;
	logic [VAR_W-1:0]            excess_w;
	logic signed [`PIX_W:0]      diff;
	logic signed [`PIX_W+GAIN_W+1:0] prod;
	logic signed [RES_W-1:0]     adj;
	logic signed [RES_W-1:0]     res;

	assign wr_sel = strm.block_first ? '0 : wr_idx;

	// block mean and variance, both truncated by the /64
	assign mean_w   = block_sum[`SUM_W-1:IDX_W];
	assign mean_sq  = VAR_W'(mean_w) * VAR_W'(mean_w);
	assign msq      = block_sumsq[`SUMSQ_W-1:IDX_W];
	assign var_w    = (msq > mean_sq) ? msq - mean_sq : '0;
	assign excess_w = (var_w > nv_q) ? var_w - nv_q : '0;

	assign rem_sub = rem - {1'b0, var_q};

	// gain * (pixel - mean) / 256, floored
	assign diff = $signed({1'b0, pix_buf[rd_idx]}) - $signed({1'b0, mean_q});
	assign prod = $signed({1'b0, gain_q}) * diff;
	assign adj  = RES_W'(prod >>> `GAIN_FRAC);
	assign res  = $signed({3'b000, mean_q}) + adj;

	assign out_valid = (state == F_EMIT);
	assign out_addr  = blk_addr_q + `ADDR_W'(rd_idx[IDX_W-1:`BLOCK_SHIFT]) * `ADDR_W'(fw_q)
	                 + `ADDR_W'(rd_idx[`BLOCK_SHIFT-1:0]);

	always_comb begin
		if (res < 0)
			out_pixel = '0;
		else if (res > MAXPIX)
			out_pixel = '1;
		else
			out_pixel = res[`PIX_W-1:0];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state            <= F_FILL;
			strm.filter_idle <= 1'b1;
			wr_idx           <= '0;
			rd_idx           <= '0;
			div_cnt          <= '0;
		end else begin
			if (strm.pix_valid)
				wr_idx <= wr_sel + 1'b1;
			case (state)
				F_FILL: begin
					if (strm.pix_valid && strm.block_first)
						strm.filter_idle <= 1'b0;
					if (stats_valid) begin
						div_cnt <= '0;
						state   <= F_DIVIDE;
					end
				end
				F_DIVIDE: begin
					div_cnt <= div_cnt + 1'b1;
					if (div_cnt == 4'(GAIN_W - 1)) begin  // one quotient bit per cycle
						rd_idx <= '0;
						state  <= F_EMIT;
					end
				end
				F_EMIT: begin
					rd_idx <= rd_idx + 1'b1;
					if (&rd_idx) begin
						strm.filter_idle <= 1'b1;
						state            <= F_FILL;
					end
				end
				default: state <= F_FILL;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (strm.pix_valid)
			pix_buf[wr_sel] <= strm.pix;
		if (strm.pix_valid && strm.block_first) begin
			blk_addr_q <= strm.block_addr;
			fw_q       <= frame_width;
			nv_q       <= noise_var;
		end
		if (stats_valid) begin
			mean_q <= mean_w;
			var_q  <= var_w;
			rem    <= {1'b0, excess_w};  // excess <= var, so the quotient tops out at 256
			gain_q <= '0;
		end else if (state == F_DIVIDE) begin
			// restoring step; var = 0 leaves the gain at 0
			if (var_q != '0 && rem >= {1'b0, var_q}) begin
				gain_q <= {gain_q[GAIN_W-2:0], 1'b1};
				rem    <= {rem_sub[VAR_W-1:0], 1'b0};
			end else begin
				gain_q <= {gain_q[GAIN_W-2:0], 1'b0};
				rem    <= {rem[VAR_W-1:0], 1'b0};
			end
		end
	end

endmodule

//--- src/wiener_pkg.sv
// shared types only; pixel width follows PIX_W from the consts header
`include "wiener_consts.svh"

package wiener_pkg;

	typedef logic [`PIX_W-1:0] pixel_t;

	// block reader sequencing
	typedef enum logic [1:0] {
		RD_IDLE,
		RD_ISSUE,  // waiting to launch a row burst
		RD_BEATS,  // collecting the 8 beats of a row
		RD_DRAIN   // last block sent, waiting for the filter
	} reader_state_t;

	// filter sequencing, one block at a time
	typedef enum logic [1:0] {
		F_FILL,
		F_DIVIDE,
		F_EMIT
	} filter_state_t;

endpackage

//--- testbench/tb_wiener_denoise.sv
// reads testbench/wiener_tests.txt relative to the project root; memory model serves one burst at a time
`timescale 1ns/10ps
`include "wiener_consts.svh"

module tb_wiener_denoise;

	localparam int CLK_PERIOD      = 20;
	localparam int RESET_CYCLES    = 10;
	localparam int CYCLES_PER_8PIX = 40;
	localparam int MARGIN_PER_TEST = 500;

	logic                clk;
	logic                rst_n;
	logic                noise_ready;
	logic [`ADDR_W-1:0]  base_addr;
	logic [`DIM_W-1:0]   frame_width;
	logic [`DIM_W-1:0]   frame_height;
	logic [2*`PIX_W-1:0] noise_var;
	logic [`PIX_W-1:0]   rdata;
	logic                rvalid;
	logic                rlast;
	logic                rd_start;
	logic [`ADDR_W-1:0]  rd_addr;
	logic [7:0]          rd_len;
	logic                out_valid;
	logic [`PIX_W-1:0]   out_pixel;
	logic [`ADDR_W-1:0]  out_addr;
	logic                start_of_frame;
	logic                frame_done;

	// test table with one entry per data line
	string       t_name[$];
	int          t_width[$];
	int          t_height[$];
	logic [31:0] t_base[$];
	int          t_nv[$];
	string       t_pattern[$];
	int          t_count[$];

	string cur_name;
	int    cur_count;
	int    cur_nv;
	int    limit_cycles;  // 0 until the table is loaded
	int    out_cnt;
	int    sof_cnt;
	int    done_cnt;

	logic [7:0] mem [logic [31:0]];
	int         exp_pix [logic [31:0]];
	int         exp_mean [logic [31:0]];  // pixels of blocks where noise swamps the variance
	bit         seen [logic [31:0]];

	wiener_denoise_top i_dut (
		.clk            (clk),
		.rst_n          (rst_n),
		.noise_ready    (noise_ready),
		.base_addr      (base_addr),
		.frame_width    (frame_width),
		.frame_height   (frame_height),
		.noise_var      (noise_var),
		.rdata          (rdata),
		.rvalid         (rvalid),
		.rlast          (rlast),
		.rd_start       (rd_start),
		.rd_addr        (rd_addr),
		.rd_len         (rd_len),
		.out_valid      (out_valid),
		.out_pixel      (out_pixel),
		.out_addr       (out_addr),
		.start_of_frame (start_of_frame),
		.frame_done     (frame_done)
	);

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1, "testbench stopped");
	endtask

	task automatic check_value(input string test, input string what,
	                           input logic [31:0] expected, input logic [31:0] actual);
		string line;
		if (expected !== actual) begin
			line = $sformatf("ERROR %s: %s expected 0x%0h actual 0x%0h",
			                 test, what, expected, actual);
			stop_run(line);
		end
	endtask

	// folds every address byte, so neighbours in a row step by one
	function automatic logic [7:0] ramp_value(input logic [31:0] addr);
		return addr[7:0] + addr[15:8] + addr[23:16] + addr[31:24];
	endfunction

	task automatic fill_frame(input int idx);
		logic [31:0] addr;
		mem.delete();
		for (int y = 0; y < t_height[idx]; y++) begin
			for (int x = 0; x < t_width[idx]; x++) begin
				addr = t_base[idx] + 32'(y * t_width[idx] + x);
				if (t_pattern[idx] == "flat")
					mem[addr] = 8'h6c;
				else if (t_pattern[idx] == "ramp")
					mem[addr] = ramp_value(addr);
				else if (t_pattern[idx] == "random")
					mem[addr] = 8'($urandom);
				else
					stop_run({"unknown image pattern ", t_pattern[idx]});
			end
		end
	endtask

	// Wiener rule per 8x8 block with results keyed by frame address
	task automatic build_expected(input int idx);
		int          w;
		int          sum;
		int          sumsq;
		int          mean;
		int          var_b;
		int          excess;
		int          gain;
		int          p;
		int          res;
		logic [31:0] top_left;
		logic [31:0] addr;
		w = t_width[idx];
		exp_pix.delete();
		exp_mean.delete();
		seen.delete();
		for (int by = 0; by < t_height[idx]; by += 8) begin
			for (int bx = 0; bx < w; bx += 8) begin
				top_left = t_base[idx] + 32'(by * w + bx);
				sum = 0;
				sumsq = 0;
				for (int i = 0; i < 64; i++) begin
					p = int'(mem[top_left + 32'((i / 8) * w + i % 8)]);
					sum += p;
					sumsq += p * p;
				end
				mean = sum >> 6;
				var_b = (sumsq >> 6) - mean * mean;
				if (var_b < 0)
					var_b = 0;
				excess = (var_b > t_nv[idx]) ? var_b - t_nv[idx] : 0;
				gain = (var_b == 0) ? 0 : excess * 256 / var_b;
				if (gain > 256)
					gain = 256;
				for (int i = 0; i < 64; i++) begin
					addr = top_left + 32'((i / 8) * w + i % 8);
					p = int'(mem[addr]);
					res = mean + ((gain * (p - mean)) >>> 8);  // floors negative products too
					if (res < 0)
						res = 0;
					else if (res > 255)
						res = 255;
					exp_pix[addr] = res;
					if (excess == 0)
						exp_mean[addr] = mean;
				end
			end
		end
	endtask

	// reader must stay quiet for one cycle inside a burst
	task automatic burst_cycle();
		@(negedge clk);
		if (rd_start)
			stop_run($sformatf("rd_start during an outstanding burst in test %s", cur_name));
	endtask

	task automatic run_test(input int idx);
		cur_name = t_name[idx];
		cur_count = t_count[idx];
		cur_nv = t_nv[idx];
		fill_frame(idx);
		build_expected(idx);
		check_value(cur_name, "pixels in reference", 32'(cur_count), 32'(exp_pix.num()));
		out_cnt = 0;
		sof_cnt = 0;
		done_cnt = 0;
		@(negedge clk);
		base_addr = t_base[idx];
		frame_width = 16'(t_width[idx]);
		frame_height = 16'(t_height[idx]);
		noise_var = 16'(t_nv[idx]);
		noise_ready = 1'b1;
		@(negedge clk);
		noise_ready = 1'b0;
		do
			@(negedge clk);
		while (!frame_done);
		repeat (4) @(negedge clk);  // catch late or repeated strobes
		check_value(cur_name, "start_of_frame pulses", 32'd1, 32'(sof_cnt));
		check_value(cur_name, "frame_done pulses", 32'd1, 32'(done_cnt));
		check_value(cur_name, "output pixels", 32'(cur_count), 32'(out_cnt));
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// memory model with a random start delay and random gaps between beats
	initial begin
		logic [31:0] addr;
		int          wait_n;
		rdata = '0;
		rvalid = 1'b0;
		rlast = 1'b0;
		forever begin
			@(negedge clk);
			if (rd_start) begin
				check_value(cur_name, "rd_len", 32'd8, 32'(rd_len));
				addr = rd_addr;
				wait_n = $urandom_range(4, 1);
				repeat (wait_n) burst_cycle();
				for (int b = 0; b < 8; b++) begin
					if (!mem.exists(addr + 32'(b)))
						stop_run($sformatf("read outside the frame at 0x%0h in test %s",
						                   addr + 32'(b), cur_name));
					rdata = mem[addr + 32'(b)];
					rvalid = 1'b1;
					rlast = (b == 7);
					burst_cycle();
					rvalid = 1'b0;
					rlast = 1'b0;
					if (b < 7) begin
						wait_n = $urandom_range(2, 0);
						repeat (wait_n) burst_cycle();
					end
				end
			end
		end
	end

	// output checker
	always @(negedge clk) begin
		if (out_valid) begin
			if (!exp_pix.exists(out_addr))
				stop_run($sformatf("output address 0x%0h lies outside the frame in test %s",
				                   out_addr, cur_name));
			if (seen.exists(out_addr))
				stop_run($sformatf("address 0x%0h written twice in test %s", out_addr, cur_name));
			seen[out_addr] = 1'b1;
			if (exp_mean.exists(out_addr))
				check_value(cur_name, "block mean", 32'(exp_mean[out_addr]), 32'(out_pixel));
			if (cur_nv == 0)  // unity gain
				check_value(cur_name, "input pixel", 32'(mem[out_addr]), 32'(out_pixel));
			check_value(cur_name, "out_pixel", 32'(exp_pix[out_addr]), 32'(out_pixel));
			out_cnt++;
		end
		if (start_of_frame)
			sof_cnt++;
		if (frame_done) begin
			done_cnt++;
			check_value(cur_name, "outputs before frame_done", 32'(cur_count), 32'(out_cnt));
		end
	end

	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		stop_run($sformatf("timeout: the tests did not finish within %0d clock cycles",
		                   limit_cycles));
	end

	initial begin
		int          fd;
		int          n;
		int          total_pix;
		int          w;
		int          h;
		int          nv;
		int          cnt;
		logic [31:0] base;
		string       line;
		string       name;
		string       pattern;
		void'($urandom(32'h3454));
		rst_n = 1'b0;
		noise_ready = 1'b0;
		base_addr = '0;
		frame_width = '0;
		frame_height = '0;
		noise_var = '0;
		limit_cycles = 0;
		out_cnt = 0;
		sof_cnt = 0;
		done_cnt = 0;
		cur_name = "reset";
		cur_count = 0;
		cur_nv = -1;
		total_pix = 0;
		fd = $fopen("testbench/wiener_tests.txt", "r");
		if (fd == 0)
			stop_run("cannot open the test file testbench/wiener_tests.txt");
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 1 && line.getc(0) != "#") begin
				n = $sscanf(line, "%s %d %d %h %d %s %d", name, w, h, base, nv, pattern, cnt);
				if (n != 7)
					stop_run({"malformed line in the test file: ", line});
				t_name.push_back(name);
				t_width.push_back(w);
				t_height.push_back(h);
				t_base.push_back(base);
				t_nv.push_back(nv);
				t_pattern.push_back(pattern);
				t_count.push_back(cnt);
				total_pix += w * h;
			end
		end
		$fclose(fd);
		if (t_name.size() == 0)
			stop_run("the test file holds no tests");
		limit_cycles = RESET_CYCLES + total_pix / 8 * CYCLES_PER_8PIX
		             + t_name.size() * MARGIN_PER_TEST;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		for (int i = 0; i < t_name.size(); i++)
			run_test(i);
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

//--- testbench/wiener_tests.txt
# name  width  height  base_addr(hex)  noise_var  pattern(flat|ramp|random)  expected_outputs
# width and height are multiples of 8
flat_8x8        8   8   00001000  20     flat    64
ramp_nv0        16  8   00002000  0      ramp    128
rand_16x16      16  16  00010000  100    random  256
rand_32x24      32  24  00020100  400    random  768
rand_big_noise  16  16  00030000  65535  random  256
rand_nv0        8   16  00040000  0      random  128
ramp_24x8       24  8   00050040  30     ramp    192
flat_16x8       16  8   00060000  0      flat    128
